//--- align_ecc_1r1w.f
src/ecc_pkg.sv
src/mem_geom_pkg.sv
src/pipe_delay.sv
src/ecc_encode.sv
src/ecc_decode.sv
src/mem_cmd_gen.sv
src/read_return.sv
src/align_ecc_1r1w.sv
verif/align_ecc_1r1w_checker.sv
verif/align_ecc_1r1w_assertions.sv
verif/tb_align_ecc_1r1w.sv

//--- verif/tb_align_ecc_1r1w.sv
`timescale 1ns/1ps

module tb_align_ecc_1r1w;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 2;
  localparam int DRAIN = 4;
  localparam int N_RAND = 64;
  localparam int N_FWD = 32;
  localparam int N_SAME = 32;
  localparam int N_INJ = 32;
  localparam int N_ROWS = 8;
  localparam int CODE_BITS = 39;
  localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * N_RAND + 2 * N_FWD + 3 * N_SAME
                                + 4 * N_INJ + 8 * N_ROWS + 6 * DRAIN + 4;
  localparam int TIMEOUT = TOTAL_CYCLES * CLK_PERIOD * 2;

  int seed = 32'h8d16_ab9a;
  int phase = 0;
  int failed_tests;
  int total_errors;

  logic clk;
  logic arst_n;
  logic write;
  logic read;
  logic [1:0] inject;
  logic [1:0] inject_q = 2'd0;
  mem_geom_pkg::addr_t wr_adr;
  mem_geom_pkg::addr_t rd_adr;
  mem_geom_pkg::data_t din;
  mem_geom_pkg::data_t rd_dout;
  logic rd_vld;
  logic rd_fwrd;
  logic rd_serr;
  logic rd_derr;
  logic mem_write;
  logic mem_read;
  mem_geom_pkg::row_addr_t mem_wr_adr;
  mem_geom_pkg::row_addr_t mem_rd_adr;
  mem_geom_pkg::row_data_t mem_bw;
  mem_geom_pkg::row_data_t mem_din;
  mem_geom_pkg::row_data_t mem_rd_dout;
  mem_geom_pkg::row_data_t sram [mem_geom_pkg::NUM_ROWS];
  mem_geom_pkg::row_data_t rd_row_q1;
  mem_geom_pkg::row_data_t rd_row_q2;

  always #(CLK_PERIOD / 2) clk = ~clk;

  align_ecc_1r1w align_ecc_1r1w_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .write       (write),
    .wr_adr      (wr_adr),
    .din         (din),
    .read        (read),
    .rd_adr      (rd_adr),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .rd_fwrd     (rd_fwrd),
    .rd_serr     (rd_serr),
    .rd_derr     (rd_derr),
    .mem_write   (mem_write),
    .mem_wr_adr  (mem_wr_adr),
    .mem_bw      (mem_bw),
    .mem_din     (mem_din),
    .mem_read    (mem_read),
    .mem_rd_adr  (mem_rd_adr),
    .mem_rd_dout (mem_rd_dout)
  );

  align_ecc_1r1w_checker check_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .phase        (phase),
    .write        (write),
    .wr_adr       (wr_adr),
    .din          (din),
    .inject       (inject),
    .read         (read),
    .rd_adr       (rd_adr),
    .mem_read     (mem_read),
    .rd_vld       (rd_vld),
    .rd_dout      (rd_dout),
    .rd_fwrd      (rd_fwrd),
    .rd_serr      (rd_serr),
    .rd_derr      (rd_derr),
    .failed_tests (failed_tests),
    .total_errors (total_errors)
  );

  // Flip positions inside the written lane, picked from the row number.
  function automatic mem_geom_pkg::row_data_t flip_mask(input mem_geom_pkg::row_data_t bw,
                                                        input mem_geom_pkg::row_addr_t row,
                                                        input logic [1:0] count);
    mem_geom_pkg::row_data_t mask;
    int base;
    int first;
    mask = '0;
    base = 0;
    for (int i = 0; i < 4; i++) begin
      if (bw[i * CODE_BITS]) begin
        base = i * CODE_BITS;
      end
    end
    first = int'(row) % CODE_BITS;
    if (count != 2'd0) begin
      mask[base + first] = 1'b1;
    end
    if (count == 2'd2) begin
      mask[base + (first + 19) % CODE_BITS] = 1'b1;
    end
    return mask;
  endfunction

  // SRAM model reads before it writes, so a same-cycle read sees the old row.
  always @(posedge clk) begin
    inject_q <= inject;
    rd_row_q1 <= mem_read ? sram[mem_rd_adr] : '0;
    rd_row_q2 <= rd_row_q1;
    if (mem_write) begin
      sram[mem_wr_adr] <= (sram[mem_wr_adr] & ~mem_bw)
                          | ((mem_din ^ flip_mask(mem_bw, mem_wr_adr, inject_q)) & mem_bw);
    end
  end

  assign mem_rd_dout = rd_row_q2;

  function automatic mem_geom_pkg::addr_t rand_addr();
    return mem_geom_pkg::addr_t'($random(seed));
  endfunction

  function automatic mem_geom_pkg::data_t rand_data();
    return mem_geom_pkg::data_t'($random(seed));
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Random permutation of the four lanes, two bits per lane.
  function automatic logic [7:0] lane_order();
    logic [7:0] order;
    logic [1:0] tmp;
    int j;
    order = 8'b11_10_01_00;
    for (int i = 3; i > 0; i--) begin
      j = rand_below(i + 1);
      tmp = order[2*i +: 2];
      order[2*i +: 2] = order[2*j +: 2];
      order[2*j +: 2] = tmp;
    end
    return order;
  endfunction

  task automatic drive_cycle(input logic wr_en, input mem_geom_pkg::addr_t wa,
                             input mem_geom_pkg::data_t wd, input logic [1:0] inj,
                             input logic rd_en, input mem_geom_pkg::addr_t ra);
    @(posedge clk);
    #2;
    write = wr_en;
    wr_adr = wa;
    din = wd;
    inject = inj;
    read = rd_en;
    rd_adr = ra;
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, 2'd0, 1'b0, '0);
  endtask

  task automatic random_test();
    mem_geom_pkg::addr_t written [$];
    mem_geom_pkg::addr_t a;
    for (int i = 0; i < N_RAND; i++) begin
      a = rand_addr();
      written.push_back(a);
      drive_cycle(1'b1, a, rand_data(), 2'd0, 1'b0, '0);
    end
    for (int i = 0; i < N_RAND; i++) begin
      drive_cycle(1'b0, '0, '0, 2'd0, 1'b1, written[rand_below(written.size())]);
    end
  endtask

  task automatic forward_test();
    mem_geom_pkg::addr_t a;
    for (int i = 0; i < N_FWD; i++) begin
      a = rand_addr();
      drive_cycle(1'b1, a, rand_data(), 2'd0, 1'b0, '0);
      drive_cycle(1'b0, '0, '0, 2'd0, 1'b1, a);
    end
  endtask

  task automatic same_cycle_test();
    mem_geom_pkg::addr_t a;
    for (int i = 0; i < N_SAME; i++) begin
      a = rand_addr();
      drive_cycle(1'b1, a, rand_data(), 2'd0, 1'b0, '0);
      idle(1);
      drive_cycle(1'b1, a, rand_data(), 2'd0, 1'b1, a);
    end
  endtask

  task automatic inject_test(input logic [1:0] flips);
    mem_geom_pkg::addr_t addrs [N_INJ];
    for (int i = 0; i < N_INJ; i++) begin
      addrs[i] = rand_addr();
      drive_cycle(1'b1, addrs[i], rand_data(), flips, 1'b0, '0);
    end
    for (int i = 0; i < N_INJ; i++) begin
      drive_cycle(1'b0, '0, '0, 2'd0, 1'b1, addrs[i]);
    end
  endtask

  task automatic lane_test();
    mem_geom_pkg::row_addr_t row;
    logic [7:0] order;
    for (int r = 0; r < N_ROWS; r++) begin
      row = mem_geom_pkg::row_addr_t'($random(seed));
      order = lane_order();
      for (int k = 0; k < 4; k++) begin
        drive_cycle(1'b1, {row, order[2*k +: 2]}, rand_data(), 2'd0, 1'b0, '0);
      end
      order = lane_order();
      for (int k = 0; k < 4; k++) begin
        drive_cycle(1'b0, '0, '0, 2'd0, 1'b1, {row, order[2*k +: 2]});
      end
    end
  endtask

  initial begin
    #(TIMEOUT);
    $display("watchdog expired after %0d ns with the tests still running", TIMEOUT);
    $display("tests failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    write = 1'b0;
    wr_adr = '0;
    din = '0;
    inject = 2'd0;
    read = 1'b0;
    rd_adr = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    arst_n = 1'b1;
    phase = 1;
    random_test();
    idle(DRAIN);
    phase = 2;
    forward_test();
    idle(DRAIN);
    phase = 3;
    same_cycle_test();
    idle(DRAIN);
    phase = 4;
    inject_test(2'd1);
    idle(DRAIN);
    phase = 5;
    inject_test(2'd2);
    idle(DRAIN);
    phase = 6;
    lane_test();
    idle(DRAIN);
    phase = 7;
    @(negedge clk);
    #1;
    $display("assertion failures: %0d", align_ecc_1r1w_i.assertions_i.fails);
    if (failed_tests == 0 && total_errors == 0 && align_ecc_1r1w_i.assertions_i.fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- verif/align_ecc_1r1w_assertions.sv
`timescale 1ns/1ps

module align_ecc_1r1w_assertions (
  input logic                    clk,
  input logic                    arst_n,
  input logic                    write,
  input logic                    read,
  input logic                    rd_vld,
  input logic                    rd_serr,
  input logic                    rd_derr,
  input logic                    mem_write,
  input mem_geom_pkg::row_data_t mem_bw
);

  int fails = 0;

  function automatic logic one_full_lane(input mem_geom_pkg::row_data_t bw);
    mem_geom_pkg::row_data_t ones;
    logic                    hit;
    ones = {mem_geom_pkg::CODE_WIDTH{1'b1}};
    hit = 1'b0;
    for (int i = 0; i < mem_geom_pkg::WORDS_PER_ROW; i++) begin
      if (bw == (ones << (i * mem_geom_pkg::CODE_WIDTH))) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  read_to_vld: assert property (@(posedge clk) disable iff (!arst_n)
    rd_vld == $past(read, 2))
    else begin
      $error("rd_vld does not follow read by two cycles");
      fails++;
    end

  write_to_mem: assert property (@(posedge clk) disable iff (!arst_n)
    mem_write == $past(write))
    else begin
      $error("mem_write does not follow write by one cycle");
      fails++;
    end

  flags_need_vld: assert property (@(posedge clk) disable iff (!arst_n)
    (rd_serr || rd_derr) |-> rd_vld)
    else begin
      $error("error flag raised without rd_vld");
      fails++;
    end

  lane_mask: assert property (@(posedge clk) disable iff (!arst_n)
    mem_write |-> one_full_lane(mem_bw))
    else begin
      $error("mem_bw is not exactly one full lane");
      fails++;
    end

endmodule

bind align_ecc_1r1w align_ecc_1r1w_assertions assertions_i (
  .clk       (clk),
  .arst_n    (arst_n),
  .write     (write),
  .read      (read),
  .rd_vld    (rd_vld),
  .rd_serr   (rd_serr),
  .rd_derr   (rd_derr),
  .mem_write (mem_write),
  .mem_bw    (mem_bw)
);

//--- verif/align_ecc_1r1w_checker.sv
`timescale 1ns/1ps

module align_ecc_1r1w_checker (
  input  logic                clk,
  input  logic                arst_n,
  input  int                  phase,
  input  logic                write,
  input  mem_geom_pkg::addr_t wr_adr,
  input  mem_geom_pkg::data_t din,
  input  logic [1:0]          inject,
  input  logic                read,
  input  mem_geom_pkg::addr_t rd_adr,
  input  logic                mem_read,
  input  logic                rd_vld,
  input  mem_geom_pkg::data_t rd_dout,
  input  logic                rd_fwrd,
  input  logic                rd_serr,
  input  logic                rd_derr,
  output int                  failed_tests,
  output int                  total_errors
);

  localparam int READ_LATENCY = 2;
  localparam int NUM_TESTS = 6;

  typedef struct packed {
    logic                vld;
    logic                fwd; // Read lands one cycle after a write to the same word.
    logic [1:0]          flips;
    mem_geom_pkg::data_t data;
  } expect_t;

  mem_geom_pkg::data_t words [1024];
  logic [1:0]          flips [1024];
  expect_t             pending [$];
  logic                last_write = 1'b0;
  mem_geom_pkg::addr_t last_adr;
  int                  cur_phase = 0;
  int                  test_errors = 0;
  int                  reads_checked = 0;
  int                  all_reads = 0;
  string names [NUM_TESTS] = '{"random", "forward", "same cycle", "single flip",
                               "double flip", "lanes"};

  initial begin
    failed_tests = 0;
    total_errors = 0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    test_errors++;
    $display("ERROR %0d ns %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      report_mismatch(name, {31'd0, exp}, {31'd0, got});
    end
  endtask

  task automatic check_result(input expect_t e);
    compare_bit("rd_vld", e.vld, rd_vld);
    if (e.vld) begin
      reads_checked++;
      compare_bit("rd_fwrd", e.fwd, rd_fwrd);
      compare_bit("rd_serr", !e.fwd && (e.flips == 2'd1), rd_serr);
      compare_bit("rd_derr", !e.fwd && (e.flips == 2'd2), rd_derr);
      if ((e.fwd || e.flips != 2'd2) && rd_dout !== e.data) begin
        report_mismatch("rd_dout", e.data, rd_dout); // Double errors leave the data unusable.
      end
    end
  endtask

  task automatic close_test(input int id);
    if (reads_checked == 0) begin
      test_errors++;
      $display("test %0d %s returned no reads to check", id, names[id-1]);
    end
    $display("test %0d %s: %0d reads checked, %0d errors", id, names[id-1], reads_checked,
             test_errors);
    if (test_errors != 0) begin
      failed_tests++;
    end
    total_errors += test_errors;
    all_reads += reads_checked;
    test_errors = 0;
    reads_checked = 0;
  endtask

  // Outputs are stable at the falling edge, half a cycle after every update.
  always @(negedge clk) begin
    expect_t e;
    if (!arst_n) begin
      pending.delete();
      last_write = 1'b0;
    end else begin
      if (phase != cur_phase) begin
        if (cur_phase >= 1 && cur_phase <= NUM_TESTS) begin
          close_test(cur_phase);
        end
        if (phase > NUM_TESTS) begin
          $display("%0d tests run, %0d failed, %0d reads checked, %0d errors", NUM_TESTS,
                   failed_tests, all_reads, total_errors);
        end
        cur_phase = phase;
      end
      compare_bit("mem_read", read, mem_read); // Every read fetches its row, forwarded or not.
      e.vld = read;
      e.fwd = read && last_write && (last_adr == rd_adr);
      e.flips = flips[rd_adr];
      e.data = words[rd_adr]; // Holds every write from earlier cycles.
      pending.push_back(e);
      if (pending.size() > READ_LATENCY) begin
        check_result(pending.pop_front());
      end
      if (write) begin
        words[wr_adr] = din;
        flips[wr_adr] = inject;
      end
      last_write = write;
      last_adr = wr_adr;
    end
  end

endmodule

//--- src/align_ecc_1r1w.sv
`timescale 1ns/1ps

module align_ecc_1r1w (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    write,
  input  mem_geom_pkg::addr_t     wr_adr,
  input  mem_geom_pkg::data_t     din,
  input  logic                    read,
  input  mem_geom_pkg::addr_t     rd_adr,
  output logic                    rd_vld,
  output mem_geom_pkg::data_t     rd_dout,
  output logic                    rd_fwrd,
  output logic                    rd_serr,
  output logic                    rd_derr,
  output logic                    mem_write,
  output mem_geom_pkg::row_addr_t mem_wr_adr,
  output mem_geom_pkg::row_data_t mem_bw,
  output mem_geom_pkg::row_data_t mem_din,
  output logic                    mem_read,
  output mem_geom_pkg::row_addr_t mem_rd_adr,
  input  mem_geom_pkg::row_data_t mem_rd_dout
);

  mem_geom_pkg::wr_cmd_t    wr_in;
  mem_geom_pkg::wr_cmd_t    wr_reg;
  mem_geom_pkg::mem_cmd_t   mem_cmd;
  mem_geom_pkg::rd_tag_t    tag_now;
  mem_geom_pkg::rd_tag_t    tag_ret;
  mem_geom_pkg::rd_result_t result;

  assign wr_in = '{valid: write, addr: wr_adr, data: din};

  pipe_delay #(.payload_t(mem_geom_pkg::wr_cmd_t), .DEPTH(1)) wr_stage (
    .clk    (clk),
    .arst_n (arst_n),
    .in     (wr_in),
    .out    (wr_reg)
  );

  mem_cmd_gen mem_cmd_gen_i (
    .wr     (wr_reg),
    .read   (read),
    .rd_adr (rd_adr),
    .cmd    (mem_cmd),
    .tag    (tag_now)
  );

  pipe_delay #(.payload_t(mem_geom_pkg::rd_tag_t), .DEPTH(mem_geom_pkg::SRAM_DELAY)) rd_tag_pipe (
    .clk    (clk),
    .arst_n (arst_n),
    .in     (tag_now),
    .out    (tag_ret)
  );

  read_return read_return_i (
    .tag (tag_ret),
    .row (mem_rd_dout),
    .res (result)
  );

  assign mem_write = mem_cmd.write;
  assign mem_wr_adr = mem_cmd.wr_row;
  assign mem_bw = mem_cmd.bw;
  assign mem_din = mem_cmd.din;
  assign mem_read = mem_cmd.read;
  assign mem_rd_adr = mem_cmd.rd_row;

  assign rd_vld = result.vld;
  assign rd_fwrd = result.fwrd;
  assign rd_serr = result.serr;
  assign rd_derr = result.derr;
  assign rd_dout = result.dout;

endmodule

//--- src/read_return.sv
`timescale 1ns/1ps

module read_return (
  input  mem_geom_pkg::rd_tag_t    tag,
  input  mem_geom_pkg::row_data_t  row,
  output mem_geom_pkg::rd_result_t res
);

  ecc_pkg::code_word_t  lane_code;
  ecc_pkg::ecc_result_t decoded;
  logic                 check_ok;

  assign lane_code = row[tag.lane * mem_geom_pkg::CODE_WIDTH +: mem_geom_pkg::CODE_WIDTH];

  ecc_decode ecc_decode_i (
    .code   (lane_code),
    .result (decoded)
  );

  // Flags only count for a real row read whose data is not replaced.
  assign check_ok = tag.mem && !tag.fwd;

  assign res.vld = tag.valid;
  assign res.fwrd = tag.fwd;
  assign res.serr = decoded.serr && check_ok;
  assign res.derr = decoded.derr && check_ok;
  assign res.dout = tag.fwd ? tag.fwd_data : decoded.data;

endmodule

//--- src/mem_cmd_gen.sv
`timescale 1ns/1ps

module mem_cmd_gen (
  input  mem_geom_pkg::wr_cmd_t  wr,
  input  logic                   read,
  input  mem_geom_pkg::addr_t    rd_adr,
  output mem_geom_pkg::mem_cmd_t cmd,
  output mem_geom_pkg::rd_tag_t  tag
);

  localparam int PAD_WIDTH = mem_geom_pkg::ROW_WIDTH - mem_geom_pkg::CODE_WIDTH;

  mem_geom_pkg::row_addr_t wr_row;
  mem_geom_pkg::lane_t     wr_lane;
  mem_geom_pkg::row_addr_t rd_row;
  mem_geom_pkg::lane_t     rd_lane;
  ecc_pkg::check_t         wr_check;
  ecc_pkg::code_word_t     wr_code;
  mem_geom_pkg::row_data_t lane_din;
  mem_geom_pkg::row_data_t lane_mask;
  logic                    forward;

  assign wr_row = wr.addr[mem_geom_pkg::ADDR_BITS-1:mem_geom_pkg::LANE_BITS];
  assign wr_lane = wr.addr[mem_geom_pkg::LANE_BITS-1:0]; // Lane is the low address bits.
  assign rd_row = rd_adr[mem_geom_pkg::ADDR_BITS-1:mem_geom_pkg::LANE_BITS];
  assign rd_lane = rd_adr[mem_geom_pkg::LANE_BITS-1:0];

  ecc_encode ecc_encode_i (
    .data  (wr.data),
    .check (wr_check)
  );

  assign wr_code.check = wr_check;
  assign wr_code.data = wr.data;

  assign lane_din = {{PAD_WIDTH{1'b0}}, wr_code};
  assign lane_mask = {{PAD_WIDTH{1'b0}}, {mem_geom_pkg::CODE_WIDTH{1'b1}}};

  assign cmd.write = wr.valid;
  assign cmd.wr_row = wr_row;
  assign cmd.bw = lane_mask << (wr_lane * mem_geom_pkg::CODE_WIDTH);
  assign cmd.din = lane_din << (wr_lane * mem_geom_pkg::CODE_WIDTH);
  assign cmd.read = read;
  assign cmd.rd_row = rd_row;

  // The registered write reaches the SRAM in this same cycle, after the row is read.
  assign forward = read && wr.valid && (wr.addr == rd_adr);

  assign tag.valid = read;
  assign tag.mem = read;
  assign tag.fwd = forward;
  assign tag.lane = rd_lane;
  assign tag.fwd_data = wr.data;

endmodule

//--- src/ecc_decode.sv
`timescale 1ns/1ps

module ecc_decode (
  input  ecc_pkg::code_word_t  code,
  output ecc_pkg::ecc_result_t result
);

  logic [ecc_pkg::HAM_WIDTH-1:0] syndrome;
  logic                          odd_parity;
  logic                          single;
  logic                          double;

  // Stored Hamming bits folded with the recomputed ones.
  always_comb begin
    logic [ecc_pkg::HAM_WIDTH-1:0] pos;
    syndrome = code.check[ecc_pkg::HAM_WIDTH-1:0];
    for (int j = 0; j < ecc_pkg::ECC_DATA_WIDTH; j++) begin
      pos = ecc_pkg::hamming_pos(j);
      syndrome = syndrome ^ (pos & {ecc_pkg::HAM_WIDTH{code.data[j]}});
    end
  end

  assign odd_parity = ^code;

  // Odd parity means one flipped bit, either at the syndrome position or in the overall bit.
  assign single = odd_parity;
  assign double = (syndrome != '0) && !odd_parity;

  always_comb begin
    result.data = code.data;
    for (int j = 0; j < ecc_pkg::ECC_DATA_WIDTH; j++) begin
      if (single && (syndrome == ecc_pkg::hamming_pos(j))) begin
        result.data[j] = ~code.data[j]; // A check-bit position leaves the data alone.
      end
    end
    result.serr = single;
    result.derr = double;
  end

endmodule

//--- src/ecc_encode.sv
`timescale 1ns/1ps

module ecc_encode (
  input  mem_geom_pkg::data_t data,
  output ecc_pkg::check_t     check
);

  logic [ecc_pkg::HAM_WIDTH-1:0] ham;
  logic                          overall;

  // Each Hamming bit covers the data bits whose code position has that bit set.
  always_comb begin
    logic [ecc_pkg::HAM_WIDTH-1:0] pos;
    ham = '0;
    for (int j = 0; j < mem_geom_pkg::DATA_WIDTH; j++) begin
      pos = ecc_pkg::hamming_pos(j);
      for (int i = 0; i < ecc_pkg::HAM_WIDTH; i++) begin
        if (pos[i]) begin
          ham[i] = ham[i] ^ data[j];
        end
      end
    end
  end

  assign overall = ^{ham, data}; // Makes the whole coded word even parity.
  assign check = {overall, ham};

endmodule

//--- src/pipe_delay.sv
`timescale 1ns/1ps

module pipe_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH = 1
) (
  input  logic     clk,
  input  logic     arst_n,
  input  payload_t in,
  output payload_t out
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= in;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign out = stage[DEPTH-1]; // Latency is exactly DEPTH cycles.

endmodule

//--- src/mem_geom_pkg.sv
package mem_geom_pkg;

  localparam int DATA_WIDTH = ecc_pkg::ECC_DATA_WIDTH; // 32-bit user word.
  localparam int NUM_ADDR = 1024;
  localparam int ADDR_BITS = $clog2(NUM_ADDR);
  localparam int WORDS_PER_ROW = 4;
  localparam int LANE_BITS = $clog2(WORDS_PER_ROW);
  localparam int NUM_ROWS = NUM_ADDR / WORDS_PER_ROW;
  localparam int ROW_BITS = $clog2(NUM_ROWS);
  localparam int SRAM_DELAY = 2; // Read command to read data, in cycles.
  localparam int CODE_WIDTH = DATA_WIDTH + ecc_pkg::ECC_WIDTH;
  localparam int ROW_WIDTH = WORDS_PER_ROW * CODE_WIDTH;

  typedef logic [ADDR_BITS-1:0]  addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ROW_BITS-1:0]   row_addr_t;
  typedef logic [LANE_BITS-1:0]  lane_t;
  typedef logic [ROW_WIDTH-1:0]  row_data_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } wr_cmd_t;

  typedef struct packed {
    logic      write;
    row_addr_t wr_row;
    row_data_t bw; // Bit-write mask, one full lane per write.
    row_data_t din;
    logic      read;
    row_addr_t rd_row;
  } mem_cmd_t;

  typedef struct packed {
    logic  valid;
    logic  mem; // A row read was issued for this tag.
    logic  fwd;
    lane_t lane;
    data_t fwd_data;
  } rd_tag_t;

  typedef struct packed {
    logic  vld;
    logic  fwrd;
    logic  serr;
    logic  derr;
    data_t dout;
  } rd_result_t;

endpackage

//--- src/ecc_pkg.sv
package ecc_pkg;

  localparam int ECC_DATA_WIDTH = 32; // Word width covered by the code.
  localparam int HAM_WIDTH = 6;
  localparam int ECC_WIDTH = HAM_WIDTH + 1; // Hamming bits plus one overall parity bit.

  typedef logic [ECC_WIDTH-1:0] check_t;

  typedef struct packed {
    check_t                    check; // Bit 6 is the overall parity, bits 5:0 the Hamming bits.
    logic [ECC_DATA_WIDTH-1:0] data;
  } code_word_t;

  typedef struct packed {
    logic [ECC_DATA_WIDTH-1:0] data;
    logic                      serr;
    logic                      derr;
  } ecc_result_t;

  // Hamming position of data bit idx, skipping the power-of-two check positions.
  function automatic logic [HAM_WIDTH-1:0] hamming_pos(input int idx);
    int seen;
    logic [HAM_WIDTH-1:0] pos;
    seen = 0;
    pos = '0;
    for (int p = 3; p < 2 ** HAM_WIDTH; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (seen == idx) begin
          pos = HAM_WIDTH'(p);
        end
        seen++;
      end
    end
    return pos;
  endfunction

endpackage
